// File: flist.f
+incdir+hdl
hdl/mipsPkg.sv
hdl/controller.sv
hdl/alu.sv
hdl/registerFile.sv
hdl/nextPc.sv
hdl/dataMemory.sv
hdl/mipsCore.sv
tb/mipsCore_assert.sv
tb/mipsCore_tb.sv

// File: tb/mipsCore_tb.sv
`include "mips_settings.svh"

module mipsCore_tb
    import mipsPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // Reset, four directed programs, the random program and some margin
    localparam int timeoutCycles = 3 + 4 * 64 + 2000 + 100;

    typedef struct packed {
        logic [31:0] pc;
        logic        regWe;
        logic [4:0]  regAddr;
        logic [31:0] regData;
        logic        memWe;
        logic [31:0] memAddr;
        logic [31:0] memData;
        logic [3:0]  memByteEn;
    } traceT;

    logic                   clk;
    logic                   rst;
    logic [`DATA_WIDTH-1:0] instrAddr;
    logic [`DATA_WIDTH-1:0] instr;
    logic [`DATA_WIDTH-1:0] retirePc;
    logic                   regWe;
    logic [4:0]             regAddr;
    logic [`DATA_WIDTH-1:0] regData;
    logic                   memWe;
    logic [`DATA_WIDTH-1:0] memAddr;
    logic [`DATA_WIDTH-1:0] memData;
    logic [3:0]             memByteEn;

    logic [31:0] prog [64];
    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [`DMEM_WORDS];
    logic [31:0] modelPc;
    int          progLen;
    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;
    integer      seed;
    string       testName;

    mipsCore dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Instruction fetch aliases into 64 words
    always @(negedge clk) begin
        instr = prog[instrAddr[7:2]];
    end

    //////////////////////////////////////////////////////////////////////
    // Program building
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] encR(input logic [5:0] op, input logic [5:0] fn,
                                         input int rd, input int rs, input int rt,
                                         input int sh);
        return {op, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input int rt, input int rs,
                                         input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] encJ(input logic [5:0] op, input int idx);
        return {op, idx[25:0]};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[progLen[5:0]] = word;
        progLen++;
    endtask

    // Every program tail writes r24 with a value from the word index
    task automatic fillProgram();
        for (int i = 0; i < 64; i++) begin
            prog[i] = encI(ADDI, 24, 0, 'h5a00 + i);
        end
        progLen = 0;
    endtask

    // Branch over one marker instruction
    task automatic branchOver(input logic [5:0] op, input int rt, input int rs);
        emit(encI(op, rt, rs, 1));
        emit(encI(ADDI, 10, 10, 1));
    endtask

    task automatic loadArith();
        fillProgram();
        emit(encI(ADDI, 1, 0, 5));
        emit(encI(ADDI, 2, 0, -3));
        emit(encR(SPECIAL, ADD, 3, 1, 2, 0));
        emit(encR(SPECIAL, SUB, 4, 1, 2, 0));
        emit(encR(SPECIAL, AND, 5, 1, 2, 0));
        emit(encR(SPECIAL, OR, 6, 1, 2, 0));
        emit(encR(SPECIAL, NOR, 7, 1, 2, 0));
        emit(encR(SPECIAL, XOR, 8, 1, 2, 0));
        emit(encR(SPECIAL, SLT, 9, 2, 1, 0));
        emit(encR(SPECIAL, SLT, 10, 1, 2, 0));
        emit(encR(SPECIAL, SLL, 11, 0, 2, 4));
        emit(encR(SPECIAL, SRL, 12, 0, 2, 28));
        emit(encR(SPECIAL2, MUL, 13, 1, 2, 0));
        emit(encI(SLTI, 14, 2, 1));
        emit(encI(SLTI, 15, 1, -1));
        emit(encI(ANDI, 16, 2, 'hff0f));
        emit(encI(ORI, 17, 1, 'h8000));
        emit(encI(XORI, 18, 2, 'hffff));
        // Write to r0 is dropped and the read back shows zero
        emit(encR(SPECIAL, ADD, 0, 1, 2, 0));
        emit(encR(SPECIAL, ADD, 19, 0, 1, 0));
    endtask

    task automatic loadMemory();
        fillProgram();
        emit(encI(ADDI, 1, 0, 'h8765));
        emit(encR(SPECIAL, SLL, 1, 0, 1, 16));
        emit(encI(ORI, 1, 1, 'h43a1));
        emit(encI(ADDI, 2, 0, 'h5a7f));
        emit(encI(SW, 1, 0, 'h40));
        emit(encI(SB, 1, 0, 'h44));
        emit(encI(SB, 2, 0, 'h45));
        emit(encI(SB, 1, 0, 'h46));
        emit(encI(SB, 2, 0, 'h47));
        emit(encI(SH, 2, 0, 'h48));
        emit(encI(SH, 1, 0, 'h4a));
        for (int k = 0; k < 4; k++) begin
            emit(encI(LB, 4 + k, 0, 'h44 + k));
        end
        emit(encI(LH, 8, 0, 'h40));
        emit(encI(LH, 9, 0, 'h42));
        emit(encI(LH, 10, 0, 'h48));
        emit(encI(LH, 11, 0, 'h4a));
        emit(encI(LW, 12, 0, 'h40));
        emit(encI(LW, 13, 0, 'h44));
        emit(encI(LW, 14, 0, 'h48));
        emit(encI(LW, 15, 0, 'h43));
    endtask

    task automatic loadBranch();
        fillProgram();
        emit(encI(ADDI, 1, 0, 5));
        emit(encI(ADDI, 2, 0, -3));
        emit(encI(ADDI, 3, 0, 5));
        branchOver(BEQ, 3, 1);
        branchOver(BEQ, 2, 1);
        branchOver(BNE, 2, 1);
        branchOver(BNE, 3, 1);
        branchOver(BLEZ, 0, 2);
        branchOver(BLEZ, 0, 1);
        branchOver(BLEZ, 0, 0);
        branchOver(BGTZ, 0, 1);
        branchOver(BGTZ, 0, 2);
        // rt 0 is bltz and rt 1 is bgez
        branchOver(REGIMM, 0, 2);
        branchOver(REGIMM, 0, 1);
        branchOver(REGIMM, 1, 1);
        branchOver(REGIMM, 1, 2);
        branchOver(REGIMM, 1, 0);
        // Backward loop of three passes
        emit(encI(ADDI, 5, 0, 3));
        emit(encI(ADDI, 4, 4, 1));
        emit(encI(BNE, 5, 4, -2));
    endtask

    task automatic loadJump();
        fillProgram();
        emit(encI(ADDI, 1, 0, 'h30));
        emit(encJ(J, 4));
        emit(encI(ADDI, 10, 0, 1));
        emit(encI(ADDI, 10, 0, 2));
        emit(encJ(JAL, 7));
        emit(encI(ADDI, 11, 0, 3));
        emit(encJ(J, 10));
        emit(encI(ADDI, 12, 0, 4));
        emit(encR(SPECIAL, JR, 0, 31, 0, 0));
        emit(encI(ADDI, 10, 0, 3));
        emit(encR(SPECIAL, JR, 0, 1, 0, 0));
        emit(encI(ADDI, 10, 0, 4));
        emit(encI(ADDI, 13, 0, 5));
    endtask

    task automatic loadRandom();
        functT       rOps [9] = '{ADD, SUB, AND, OR, NOR, XOR, SLT, SLL, SRL};
        opcodeT      immOps [5] = '{ADDI, SLTI, ANDI, ORI, XORI};
        opcodeT      memOps [6] = '{LW, LH, LB, SW, SH, SB};
        opcodeT      brOps [4] = '{BEQ, BNE, BLEZ, BGTZ};
        logic [31:0] r;
        logic [31:0] imm;
        int          kind;
        int          sel;
        int          off;
        fillProgram();
        for (int i = 0; i < 64; i++) begin
            r = $random(seed);
            imm = $random(seed);
            kind = int'(r[3:0]) % 10;
            sel = int'(r[27:24]);
            case (kind)
                0, 1, 2: begin
                    if (sel == 9)
                        emit(encR(SPECIAL2, MUL, int'(r[18:14]), int'(r[8:4]),
                                  int'(r[13:9]), 0));
                    else
                        emit(encR(SPECIAL, rOps[sel % 9], int'(r[18:14]), int'(r[8:4]),
                                  int'(r[13:9]), int'(r[23:19])));
                end
                3, 4, 5: emit(encI(immOps[sel % 5], int'(r[13:9]), int'(r[8:4]),
                                   int'(imm[15:0])));
                6, 7: begin
                    // Based on r0 with aligned offsets inside the data memory
                    off = (sel % 3 == 0) ? int'(imm[7:0]) * 4 :
                          (sel % 3 == 1) ? int'(imm[8:0]) * 2 : int'(imm[9:0]);
                    emit(encI(memOps[(kind - 6) * 3 + sel % 3], int'(r[13:9]), 0, off));
                end
                8: begin
                    off = int'(r[29:24]) - (i + 1);
                    if (sel % 6 < 4)
                        emit(encI(brOps[sel % 6], int'(r[13:9]), int'(r[8:4]), off));
                    else
                        emit(encI(REGIMM, sel % 6 - 4, int'(r[8:4]), off));
                end
                default: emit(encJ(r[31] ? JAL : J, int'(r[29:24])));
            endcase
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    task automatic resetModel();
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < `DMEM_WORDS; i++) begin
            modelMem[i] = '0;
        end
        modelPc = '0;
    endtask

    // Executes one instruction and returns its retire trace
    function automatic traceT step(input logic [31:0] ins);
        traceT       t;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  wa;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] se;
        logic [31:0] ze;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] wv;
        logic [31:0] nextAddr;
        logic [15:0] half;
        logic [7:0]  byteVal;
        logic        we;
        logic        taken;
        op = ins[31:26];
        fn = ins[5:0];
        rs = ins[25:21];
        rt = ins[20:16];
        a = modelRegs[rs];
        b = modelRegs[rt];
        se = {{16{ins[15]}}, ins[15:0]};
        ze = {16'h0000, ins[15:0]};
        addr = a + se;
        word = modelMem[addr[9:2]];
        nextAddr = modelPc + 4;
        wa = ins[15:11];
        wv = '0;
        we = 1'b0;
        taken = 1'b0;
        t = '0;
        t.pc = modelPc;
        case (op)
            SPECIAL: begin
                we = 1'b1;
                case (fn)
                    ADD: wv = a + b;
                    SUB: wv = a - b;
                    AND: wv = a & b;
                    OR:  wv = a | b;
                    NOR: wv = ~(a | b);
                    XOR: wv = a ^ b;
                    SLT: wv = {31'b0, $signed(a) < $signed(b)};
                    SLL: wv = b << ins[10:6];
                    SRL: wv = b >> ins[10:6];
                    default: begin
                        we = 1'b0;
                        if (fn == JR)
                            nextAddr = a;
                    end
                endcase
            end
            SPECIAL2: begin
                we = (fn == MUL);
                wv = a * b;
            end
            ADDI, SLTI, ANDI, ORI, XORI: begin
                we = 1'b1;
                wa = rt;
                case (op)
                    ADDI: wv = a + se;
                    SLTI: wv = {31'b0, $signed(a) < $signed(se)};
                    ANDI: wv = a & ze;
                    ORI:  wv = a | ze;
                    default: wv = a ^ ze;
                endcase
            end
            LB, LH, LW: begin
                we = 1'b1;
                wa = rt;
                half = addr[1] ? word[31:16] : word[15:0];
                byteVal = word[8 * addr[1:0] +: 8];
                case (op)
                    LB: wv = {{24{byteVal[7]}}, byteVal};
                    LH: wv = {{16{half[15]}}, half};
                    default: wv = word;
                endcase
            end
            SB, SH, SW: begin
                t.memWe = 1'b1;
                t.memAddr = addr;
                case (op)
                    SB: begin
                        t.memData = {4{b[7:0]}};
                        t.memByteEn = 4'b0001 << addr[1:0];
                    end
                    SH: begin
                        t.memData = {2{b[15:0]}};
                        t.memByteEn = addr[1] ? 4'b1100 : 4'b0011;
                    end
                    default: begin
                        t.memData = b;
                        t.memByteEn = 4'b1111;
                    end
                endcase
                for (int lane = 0; lane < 4; lane++) begin
                    if (t.memByteEn[lane])
                        modelMem[addr[9:2]][lane*8 +: 8] = t.memData[lane*8 +: 8];
                end
            end
            BEQ:    taken = (a == b);
            BNE:    taken = (a != b);
            BLEZ:   taken = ($signed(a) <= 0);
            BGTZ:   taken = ($signed(a) > 0);
            REGIMM: taken = (rt == 5'd0) ? a[31] : (rt == 5'd1) ? !a[31] : 1'b0;
            J:      nextAddr = {nextAddr[31:28], ins[25:0], 2'b00};
            JAL: begin
                we = 1'b1;
                wa = 5'd31;
                wv = modelPc + 4;
                nextAddr = {nextAddr[31:28], ins[25:0], 2'b00};
            end
            default: ;
        endcase
        if (taken)
            nextAddr = modelPc + 4 + {se[29:0], 2'b00};
        if (we) begin
            t.regWe = 1'b1;
            t.regAddr = wa;
            t.regData = wv;
            if (wa != 5'd0)
                modelRegs[wa] = wv;
        end
        modelPc = nextAddr;
        return t;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////////////////////////

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     testName, what, expected, actual);
        end
    endtask

    task automatic finishRun();
        errorCount += dut_i.assertions_i.failCount;
        $display("Checks: %0d, errors: %0d (assertion failures: %0d)",
                 checkCount, errorCount, dut_i.assertions_i.failCount);
        if (errorCount == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    endtask

    always @(posedge clk) begin
        traceT exp;
        cycleCount++;
        if (rst) begin
            resetModel();
            checkValue("regWe in reset", 32'(1'b0), 32'(regWe));
            checkValue("memWe in reset", 32'(1'b0), 32'(memWe));
            checkValue("memByteEn in reset", 32'(4'b0000), 32'(memByteEn));
        end else begin
            exp = step(prog[modelPc[7:2]]);
            checkValue("instrAddr", exp.pc, instrAddr);
            checkValue("retirePc", exp.pc, retirePc);
            checkValue("regWe", 32'(exp.regWe), 32'(regWe));
            checkValue("memWe", 32'(exp.memWe), 32'(memWe));
            checkValue("memByteEn", 32'(exp.memByteEn), 32'(memByteEn));
            if (exp.regWe) begin
                checkValue("regAddr", 32'(exp.regAddr), 32'(regAddr));
                checkValue("regData", exp.regData, regData);
            end
            if (exp.memWe) begin
                checkValue("memAddr", exp.memAddr, memAddr);
                checkValue("memData", exp.memData, memData);
            end
        end
        if (cycleCount > timeoutCycles) begin
            $display("Timeout: the run did not end within %0d cycles", timeoutCycles);
            errorCount++;
            finishRun();
        end
    end

    // Three reset cycles before the program runs
    task automatic runCycles(input int cycles);
        repeat (3) @(negedge clk);
        rst = 1'b0;
        repeat (cycles) @(negedge clk);
    endtask

    initial begin
        seed = 15;
        rst = 1'b1;
        instr = '0;
        testName = "arithmetic";
        loadArith();
        runCycles(64);
        rst = 1'b1;
        testName = "memory";
        loadMemory();
        runCycles(64);
        rst = 1'b1;
        testName = "branch";
        loadBranch();
        runCycles(64);
        rst = 1'b1;
        testName = "jump";
        loadJump();
        runCycles(64);
        rst = 1'b1;
        testName = "random";
        loadRandom();
        runCycles(2000);
        finishRun();
    end

endmodule

// File: tb/mipsCore_assert.sv
`include "mips_settings.svh"

module mipsCore_assert (
    input logic                   clk,
    input logic                   rst,
    input logic [`DATA_WIDTH-1:0] retirePc,
    input logic                   regWe,
    input logic                   memWe,
    input logic [3:0]             memByteEn
);
    timeunit 1ns;
    timeprecision 1ps;

    // Number of assertion failures so far
    int failCount = 0;

    noDualWrite: assert property (@(posedge clk) disable iff (rst) !(regWe && memWe))
        else begin
            failCount++;
            $error("Register write and memory write in the same cycle");
        end

    pcAligned: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(retirePc) && retirePc[1:0] == 2'b00)
        else begin
            failCount++;
            $error("Retire PC is unknown or not word aligned");
        end

    // Lanes are marked only for a store
    byteEnableMatch: assert property (@(posedge clk) disable iff (rst)
        (memByteEn != 4'b0000) == memWe)
        else begin
            failCount++;
            $error("Byte enables do not match the memory write");
        end

endmodule

bind mipsCore mipsCore_assert assertions_i (.*);

// File: hdl/mipsCore.sv
`include "mips_settings.svh"

module mipsCore
    import mipsPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    output logic [`DATA_WIDTH-1:0] instrAddr,
    input  logic [`DATA_WIDTH-1:0] instr,

    // Retire trace
    output logic [`DATA_WIDTH-1:0] retirePc,
    output logic                   regWe,
    output logic [4:0]             regAddr,
    output logic [`DATA_WIDTH-1:0] regData,
    output logic                   memWe,
    output logic [`DATA_WIDTH-1:0] memAddr,
    output logic [`DATA_WIDTH-1:0] memData,
    output logic [3:0]             memByteEn
);

    // Instruction fields
    opcodeT      opcode;
    functT       funct;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    logic [15:0] imm;
    logic [25:0] index;

    // Decoder levels
    logic     regWrite;
    aluOpT    aluOp;
    logic     aluSrc;
    logic     zeroExt;
    regDstT   regDst;
    logic     memWrite;
    logic     memRead;
    memToRegT memToReg;
    branchT   branchKind;
    logic     jump;
    logic     jumpReg;
    accessT   loadSize;
    accessT   storeSize;

    // Datapath
    logic [`DATA_WIDTH-1:0] pc;
    logic [`DATA_WIDTH-1:0] pcPlus4;
    logic [`DATA_WIDTH-1:0] rsValue;
    logic [`DATA_WIDTH-1:0] rtValue;
    logic [`DATA_WIDTH-1:0] immExt;
    logic [`DATA_WIDTH-1:0] aluB;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic [`DATA_WIDTH-1:0] memReadData;
    logic [`DATA_WIDTH-1:0] loadValue;

    assign opcode = opcodeT'(instr[31:26]);
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign funct  = functT'(instr[5:0]);
    assign imm    = instr[15:0];
    assign index  = instr[25:0];

    controller controller_i (
        .opcode(opcode), .funct(funct), .rt(rt),
        .regWrite(regWrite), .aluOp(aluOp), .aluSrc(aluSrc), .zeroExt(zeroExt),
        .regDst(regDst), .memWrite(memWrite), .memRead(memRead), .memToReg(memToReg),
        .branchKind(branchKind), .jump(jump), .jumpReg(jumpReg),
        .loadSize(loadSize), .storeSize(storeSize)
    );

    nextPc nextPc_i (
        .clk(clk), .rst(rst), .branchKind(branchKind), .jump(jump), .jumpReg(jumpReg),
        .rsValue(rsValue), .rtValue(rtValue), .immediate(imm), .target(index),
        .pc(pc), .pcPlus4(pcPlus4)
    );

    registerFile registerFile_i (
        .clk(clk), .rst(rst), .readAddrA(rs), .readAddrB(rt),
        .writeAddr(regAddr), .writeEnable(regWe), .writeData(regData),
        .readDataA(rsValue), .readDataB(rtValue)
    );

    // Logic immediates are zero extended, all others sign extended
    assign immExt = zeroExt ? {{(`DATA_WIDTH-16){1'b0}}, imm}
                            : {{(`DATA_WIDTH-16){imm[15]}}, imm};
    assign aluB   = aluSrc ? immExt : rtValue;

    alu alu_i (.a(rsValue), .b(aluB), .shamt(shamt), .op(aluOp), .result(aluResult));

    dataMemory dataMemory_i (
        .clk(clk), .rst(rst), .address(aluResult), .writeData(rtValue), .write(memWe),
        .storeSize(storeSize), .loadSize(loadSize), .readData(memReadData),
        .byteEnable(memByteEn), .laneData(memData)
    );

    assign loadValue = memRead ? memReadData : '0;

    //////////////////////////////////////////////////////////////////////
    // Write-back and trace
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (regDst)
            DST_RD:  regAddr = rd;
            DST_RA:  regAddr = 5'd31;
            default: regAddr = rt;
        endcase
        case (memToReg)
            WB_MEM:  regData = loadValue;
            WB_LINK: regData = pcPlus4;
            default: regData = aluResult;
        endcase
    end

    // Writes held off while reset is high
    assign regWe     = regWrite & ~rst;
    assign memWe     = memWrite & ~rst;
    assign memAddr   = aluResult;
    assign instrAddr = pc;
    assign retirePc  = pc;

endmodule

// File: hdl/dataMemory.sv
`include "mips_settings.svh"

module dataMemory
    import mipsPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`DATA_WIDTH-1:0] address,
    input  logic [`DATA_WIDTH-1:0] writeData,
    input  logic                   write,
    input  accessT                 storeSize,
    input  accessT                 loadSize,
    output logic [`DATA_WIDTH-1:0] readData,
    output logic [3:0]             byteEnable,
    output logic [`DATA_WIDTH-1:0] laneData
);

    localparam int idxWidth = $clog2(`DMEM_WORDS);

    logic [`DATA_WIDTH-1:0] mem [`DMEM_WORDS];
    logic [idxWidth-1:0]    wordIndex;
    logic [`DATA_WIDTH-1:0] word;
    logic [15:0]            half;
    logic [7:0]             byteVal;

    assign wordIndex = address[idxWidth+1:2];

    //////////////////////////////////////////////////////////////////////
    // Store side
    //////////////////////////////////////////////////////////////////////

    // Sub-word data copied into every lane, enables pick the target
    always_comb begin
        case (storeSize)
            ACC_HALF: begin
                laneData   = {2{writeData[15:0]}};
                byteEnable = address[1] ? 4'b1100 : 4'b0011;
            end
            ACC_BYTE: begin
                laneData   = {4{writeData[7:0]}};
                byteEnable = 4'b0001 << address[1:0];
            end
            default: begin
                laneData   = writeData;
                byteEnable = 4'b1111;
            end
        endcase
        if (!write)
            byteEnable = 4'b0000;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byteEnable[lane])
                    mem[wordIndex][lane*8 +: 8] <= laneData[lane*8 +: 8];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Load side
    //////////////////////////////////////////////////////////////////////

    assign word    = mem[wordIndex];
    assign half    = address[1] ? word[31:16] : word[15:0];
    assign byteVal = word[{address[1:0], 3'b000} +: 8];

    always_comb begin
        case (loadSize)
            ACC_HALF: readData = {{(`DATA_WIDTH-16){half[15]}}, half};
            ACC_BYTE: readData = {{(`DATA_WIDTH-8){byteVal[7]}}, byteVal};
            default:  readData = word;
        endcase
    end

endmodule

// File: hdl/nextPc.sv
`include "mips_settings.svh"

module nextPc
    import mipsPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  branchT                 branchKind,
    input  logic                   jump,
    input  logic                   jumpReg,
    input  logic [`DATA_WIDTH-1:0] rsValue,
    input  logic [`DATA_WIDTH-1:0] rtValue,
    input  logic [15:0]            immediate,
    input  logic [25:0]            target,
    output logic [`DATA_WIDTH-1:0] pc,
    output logic [`DATA_WIDTH-1:0] pcPlus4
);

    logic [`DATA_WIDTH-1:0] branchTarget;
    logic [`DATA_WIDTH-1:0] jumpTarget;
    logic [`DATA_WIDTH-1:0] pcNext;
    logic                   taken;

    assign pcPlus4      = pc + 4;
    assign branchTarget = pcPlus4 + {{(`DATA_WIDTH-18){immediate[15]}}, immediate, 2'b00};
    // Region bits from pc+4, index fills the rest
    assign jumpTarget   = {pcPlus4[`DATA_WIDTH-1 -: 4], target, 2'b00};

    // Signed compares against rt or against zero
    always_comb begin
        case (branchKind)
            BR_EQ:   taken = (rsValue == rtValue);
            BR_NE:   taken = (rsValue != rtValue);
            BR_LEZ:  taken = ($signed(rsValue) <= 0);
            BR_GTZ:  taken = ($signed(rsValue) > 0);
            BR_LTZ:  taken = rsValue[`DATA_WIDTH-1];
            BR_GEZ:  taken = !rsValue[`DATA_WIDTH-1];
            default: taken = 1'b0;
        endcase
    end

    assign pcNext = jumpReg ? rsValue :
                    jump    ? jumpTarget :
                    taken   ? branchTarget : pcPlus4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

// File: hdl/registerFile.sv
`include "mips_settings.svh"

module registerFile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [4:0]             readAddrA,
    input  logic [4:0]             readAddrB,
    input  logic [4:0]             writeAddr,
    input  logic                   writeEnable,
    input  logic [`DATA_WIDTH-1:0] writeData,
    output logic [`DATA_WIDTH-1:0] readDataA,
    output logic [`DATA_WIDTH-1:0] readDataB
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    // Register zero always reads as zero
    assign readDataA = (readAddrA == 5'd0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == 5'd0) ? '0 : regs[readAddrB];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

// File: hdl/alu.sv
`include "mips_settings.svh"

module alu
    import mipsPkg::*;
(
    input  logic [`DATA_WIDTH-1:0] a,
    input  logic [`DATA_WIDTH-1:0] b,
    input  logic [4:0]             shamt,
    input  aluOpT                  op,
    output logic [`DATA_WIDTH-1:0] result
);

    // Full signed product, only the low word is kept
    logic signed [2*`DATA_WIDTH-1:0] product;
    logic                            lessThan;

    assign product  = $signed(a) * $signed(b);
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_NOR: result = ~(a | b);
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {{(`DATA_WIDTH-1){1'b0}}, lessThan};

            // Shifts act on the rt operand
            ALU_SLL: result = b << shamt;
            ALU_SRL: result = b >> shamt;

            ALU_MUL: result = product[`DATA_WIDTH-1:0];
            default: result = '0;
        endcase
    end

endmodule

// File: hdl/controller.sv
module controller
    import mipsPkg::*;
(
    input  opcodeT     opcode,
    input  functT      funct,
    input  logic [4:0] rt,

    output logic       regWrite,
    output aluOpT      aluOp,
    output logic       aluSrc,
    output logic       zeroExt,
    output regDstT     regDst,
    output logic       memWrite,
    output logic       memRead,
    output memToRegT   memToReg,
    output branchT     branchKind,
    output logic       jump,
    output logic       jumpReg,
    output accessT     loadSize,
    output accessT     storeSize
);

    // Set when SPECIAL carries a known ALU function
    logic rValid;

    always_comb begin
        // Everything off, so unknown encodings retire as no-ops
        regWrite   = 1'b0;
        aluOp      = ALU_ADD;
        aluSrc     = 1'b0;
        zeroExt    = 1'b0;
        regDst     = DST_RT;
        memWrite   = 1'b0;
        memRead    = 1'b0;
        memToReg   = WB_ALU;
        branchKind = BR_NONE;
        jump       = 1'b0;
        jumpReg    = 1'b0;
        loadSize   = ACC_WORD;
        storeSize  = ACC_WORD;
        rValid     = 1'b0;

        case (opcode)
            SPECIAL: begin
                rValid = 1'b1;
                case (funct)
                    ADD: aluOp = ALU_ADD;
                    SUB: aluOp = ALU_SUB;
                    AND: aluOp = ALU_AND;
                    OR:  aluOp = ALU_OR;
                    NOR: aluOp = ALU_NOR;
                    XOR: aluOp = ALU_XOR;
                    SLT: aluOp = ALU_SLT;
                    SLL: aluOp = ALU_SLL;
                    SRL: aluOp = ALU_SRL;
                    JR: begin
                        rValid  = 1'b0;
                        jumpReg = 1'b1;
                    end
                    default: rValid = 1'b0;
                endcase
                if (rValid) begin
                    regWrite = 1'b1;
                    regDst   = DST_RD;
                end
            end

            SPECIAL2: begin
                if (funct == MUL) begin
                    aluOp    = ALU_MUL;
                    regWrite = 1'b1;
                    regDst   = DST_RD;
                end
            end

            // Immediate ALU group, logic ops take zero extension
            ADDI, SLTI, ANDI, ORI, XORI: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                case (opcode)
                    SLTI:    aluOp = ALU_SLT;
                    ANDI:    aluOp = ALU_AND;
                    ORI:     aluOp = ALU_OR;
                    XORI:    aluOp = ALU_XOR;
                    default: aluOp = ALU_ADD;
                endcase
                zeroExt = (opcode == ANDI) || (opcode == ORI) || (opcode == XORI);
            end

            LB, LH, LW: begin
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                memRead  = 1'b1;
                memToReg = WB_MEM;
                loadSize = (opcode == LB) ? ACC_BYTE :
                           (opcode == LH) ? ACC_HALF : ACC_WORD;
            end

            SB, SH, SW: begin
                aluSrc    = 1'b1;
                memWrite  = 1'b1;
                storeSize = (opcode == SB) ? ACC_BYTE :
                            (opcode == SH) ? ACC_HALF : ACC_WORD;
            end

            // bltz and bgez share REGIMM, rt tells them apart
            REGIMM: begin
                if (rt == 5'd0)
                    branchKind = BR_LTZ;
                else if (rt == 5'd1)
                    branchKind = BR_GEZ;
            end
            BEQ:  branchKind = BR_EQ;
            BNE:  branchKind = BR_NE;
            BLEZ: branchKind = BR_LEZ;
            BGTZ: branchKind = BR_GTZ;

            J: jump = 1'b1;
            JAL: begin
                jump     = 1'b1;
                regWrite = 1'b1;
                regDst   = DST_RA;
                memToReg = WB_LINK;
            end

            default: ;
        endcase
    end

endmodule

// File: hdl/mipsPkg.sv
package mipsPkg;

    //////////////////////////////////////////////////////////////////////
    // Instruction fields
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        SPECIAL  = 6'b000000, REGIMM = 6'b000001, J    = 6'b000010,
        JAL      = 6'b000011, BEQ    = 6'b000100, BNE  = 6'b000101,
        BLEZ     = 6'b000110, BGTZ   = 6'b000111, ADDI = 6'b001000,
        SLTI     = 6'b001010, ANDI   = 6'b001100, ORI  = 6'b001101,
        XORI     = 6'b001110, SPECIAL2 = 6'b011100, LB = 6'b100000,
        LH       = 6'b100001, LW     = 6'b100011, SB   = 6'b101000,
        SH       = 6'b101001, SW     = 6'b101011
    } opcodeT;

    typedef enum logic [5:0] {
        SLL = 6'b000000, SRL = 6'b000010, JR  = 6'b001000,
        ADD = 6'b100000, SUB = 6'b100010, AND = 6'b100100,
        OR  = 6'b100101, XOR = 6'b100110, NOR = 6'b100111,
        SLT = 6'b101010
    } functT;

    // mul sits under SPECIAL2 and reuses the SRL function code
    parameter functT MUL = SRL;

    //////////////////////////////////////////////////////////////////////
    // Control levels
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOR,
        ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_MUL
    } aluOpT;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
    } branchT;

    typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} regDstT;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} memToRegT;

    typedef enum logic [1:0] {ACC_WORD, ACC_HALF, ACC_BYTE} accessT;

endpackage

// File: hdl/mips_settings.svh
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Core dimensions
//////////////////////////////////////////////////////////////////////

// Width of a data word and of the PC
`define DATA_WIDTH 32

// Architectural registers, register zero included
`define REG_COUNT 32

// Data memory depth in words, 1 KiB in total
`define DMEM_WORDS 256

`endif
